//--- build.f
logic/vsm_cmd_pkg.sv
logic/vsm_mem_pkg.sv
logic/vsm_sequencer.sv
logic/vsm_addr_counter.sv
logic/vsm_rom_array.sv
logic/vsm_serializer.sv
logic/vsm_top.sv
test/vsm_clk_gen.sv
test/vsm_sva.sv
test/vsm_tb.sv

//--- logic/vsm_addr_counter.sv
`timescale 1ns/100ps

module vsm_addr_counter (
   input  logic                              clk,
   input  logic                              rst_n_i,
   input  vsm_cmd_pkg::host_cmd_t            host_i,
   input  logic [2:0]                        load_step_i,
   input  vsm_mem_pkg::fetch_ctl_t           ctl_i,
   input  vsm_mem_pkg::rom_byte_t            rd_data_i,
   output logic [vsm_mem_pkg::ADDR_W-1:0]    ptr_o
);

   logic [vsm_mem_pkg::ADDR_W-1:0] ptr_q;
   vsm_mem_pkg::rom_byte_t         lo_q;
   logic                           cmd_load;

   assign cmd_load = host_i.strobe && (host_i.mode == vsm_cmd_pkg::CMD_LOAD);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ptr_q <= '0;
      end else if (cmd_load) begin
         case (load_step_i)
            3'd0: ptr_q[3:0]   <= host_i.nibble;
            3'd1: ptr_q[7:4]   <= host_i.nibble;
            3'd2: ptr_q[11:8]  <= host_i.nibble;
            3'd3: ptr_q[15:12] <= host_i.nibble;
            3'(vsm_cmd_pkg::LOAD_STEPS - 1):
               ptr_q[vsm_mem_pkg::ADDR_W-1:16] <= host_i.nibble[1:0];
            default: ;   // Extra loads are ignored
         endcase
      end else if (ctl_i.jump) begin
         // Bits above the branch field stay as loaded
         ptr_q[vsm_mem_pkg::BRANCH_AW-1:0] <=
            {rd_data_i[vsm_mem_pkg::BRANCH_HI_W-1:0], lo_q};
      end else if (ctl_i.fetch) begin
         ptr_q <= ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ctl_i.lo_capture)
         lo_q <= rd_data_i;   // First branch byte
   end

   assign ptr_o = ptr_q;

endmodule

//--- logic/vsm_cmd_pkg.sv
package vsm_cmd_pkg;

   // Mode pair as seen on the pins, {m0, m1}
   typedef enum logic [1:0] {
      CMD_IDLE   = 2'b00,
      CMD_LOAD   = 2'b01,
      CMD_READ   = 2'b10,
      CMD_BRANCH = 2'b11
   } vsm_cmd_e;

   localparam int NIBBLE_W = 4;   // add8..add1

   // Five nibble loads fill the 18-bit pointer, the last one only two bits wide
   localparam int LOAD_STEPS = 5;

   typedef struct packed {
      vsm_cmd_e              mode;
      logic [NIBBLE_W-1:0]   nibble;
      logic                  strobe;   // Clk_en from the synthesizer
   } host_cmd_t;

endpackage

//--- logic/vsm_mem_pkg.sv
package vsm_mem_pkg;

   localparam int ROM_DEPTH = 16384;
   localparam int ROM_AW    = $clog2(ROM_DEPTH);   // Upper pointer bits wrap
   localparam int ADDR_W    = 18;

   // Read-and-Branch replaces the low 14 pointer bits only
   localparam int BRANCH_AW   = 14;
   localparam int BRANCH_HI_W = BRANCH_AW - 8;   // Bits taken from the second byte

   typedef logic [7:0] rom_byte_t;

   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      rom_byte_t         dat;
      logic              we;
      logic              sel;
      logic              stb;
      logic              cyc;
   } bus_req_t;

   typedef struct packed {
      rom_byte_t dat;
      logic      ack;
   } bus_rsp_t;

   // One-cycle pulses from the sequencer
   typedef struct packed {
      logic fetch;        // Read at pointer, then increment
      logic fill;         // Fetched byte into read-ahead buffer
      logic lo_capture;   // Keep branch low byte
      logic jump;         // Load branch target
   } fetch_ctl_t;

endpackage

//--- logic/vsm_rom_array.sv
`timescale 1ns/100ps

module vsm_rom_array (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  vsm_mem_pkg::bus_req_t           bus_i,
   output vsm_mem_pkg::bus_rsp_t           bus_o,
   input  vsm_mem_pkg::fetch_ctl_t         ctl_i,
   input  logic [vsm_mem_pkg::ADDR_W-1:0]  ptr_i,
   output vsm_mem_pkg::rom_byte_t          rd_data_o,
   output logic                            fetch_valid_o
);

   vsm_mem_pkg::rom_byte_t         mem [vsm_mem_pkg::ROM_DEPTH];
   vsm_mem_pkg::rom_byte_t         fetch_q;
   vsm_mem_pkg::rom_byte_t         bus_dat_q;
   logic [vsm_mem_pkg::ROM_AW-1:0] rd_idx;
   logic [vsm_mem_pkg::ROM_AW-1:0] wr_idx;
   logic                           bus_act;
   logic                           host_wr;
   logic                           host_rd;
   logic                           ack_q;
   logic                           valid_q;

   assign bus_act = bus_i.cyc && bus_i.stb;
   assign host_wr = bus_act && bus_i.we;
   assign host_rd = bus_act && !bus_i.we;

   // Single read port, fetch wins over the host
   assign rd_idx = ctl_i.fetch ? ptr_i[vsm_mem_pkg::ROM_AW-1:0]
                               : bus_i.adr[vsm_mem_pkg::ROM_AW-1:0];
   assign wr_idx = bus_i.adr[vsm_mem_pkg::ROM_AW-1:0];

   always_ff @(posedge clk) begin
      if (host_wr && bus_i.sel)
         mem[wr_idx] <= bus_i.dat;
      if (ctl_i.fetch)
         fetch_q <= mem[rd_idx];
      else if (host_rd)
         bus_dat_q <= mem[rd_idx];
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q   <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         // Reads wait out a fetch, writes never do
         ack_q   <= bus_act && !ack_q && (bus_i.we || !ctl_i.fetch);
         valid_q <= ctl_i.fetch;
      end
   end

   assign bus_o.dat     = bus_dat_q;
   assign bus_o.ack     = ack_q;
   assign rd_data_o     = fetch_q;
   assign fetch_valid_o = valid_q;

endmodule

//--- logic/vsm_sequencer.sv
`timescale 1ns/100ps

module vsm_sequencer (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  vsm_cmd_pkg::host_cmd_t  host_i,
   input  logic                    byte_done_i,
   input  logic                    fetch_valid_i,
   output vsm_mem_pkg::fetch_ctl_t ctl_o,
   output logic [2:0]              load_step_o,
   output logic                    read_step_o,
   output logic                    restart_o
);

   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      FILL,
      BR_LO,
      BR_LO_WAIT,
      BR_HI,
      BR_HI_WAIT,
      JUMP
   } seq_state_e;

   seq_state_e              state_q;
   seq_state_e              state_d;
   vsm_mem_pkg::fetch_ctl_t ctl_q;
   vsm_mem_pkg::fetch_ctl_t ctl_d;
   logic [2:0]              step_q;
   logic                    restart_q;
   logic                    cmd_load;
   logic                    cmd_read;
   logic                    cmd_branch;

   assign cmd_load   = host_i.strobe && (host_i.mode == vsm_cmd_pkg::CMD_LOAD);
   assign cmd_read   = host_i.strobe && (host_i.mode == vsm_cmd_pkg::CMD_READ);
   assign cmd_branch = host_i.strobe && (host_i.mode == vsm_cmd_pkg::CMD_BRANCH);

   // State names the step whose pulse is issued on leaving it
   always_comb begin
      state_d = state_q;
      ctl_d   = '0;
      case (state_q)
         IDLE: begin
            if (byte_done_i) begin
               state_d     = FETCH;
               ctl_d.fetch = 1'b1;
            end
         end
         FETCH:   state_d = FILL;
         FILL: begin
            if (fetch_valid_i) begin
               state_d    = IDLE;
               ctl_d.fill = 1'b1;
            end
         end
         BR_LO:   state_d = BR_LO_WAIT;
         BR_LO_WAIT: begin
            if (fetch_valid_i) begin
               state_d          = BR_HI;
               ctl_d.lo_capture = 1'b1;
            end
         end
         BR_HI: begin
            state_d     = BR_HI_WAIT;
            ctl_d.fetch = 1'b1;   // High byte
         end
         BR_HI_WAIT: begin
            if (fetch_valid_i) begin
               state_d    = JUMP;
               ctl_d.jump = 1'b1;
            end
         end
         JUMP: begin
            state_d     = FETCH;
            ctl_d.fetch = 1'b1;   // Target byte
         end
         default: state_d = IDLE;
      endcase

      // A branch restarts the sequence from anywhere
      if (cmd_branch) begin
         state_d     = BR_LO;
         ctl_d       = '0;
         ctl_d.fetch = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= IDLE;
         ctl_q     <= '0;
         step_q    <= 3'd0;
         restart_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         ctl_q     <= ctl_d;
         restart_q <= cmd_load || cmd_branch;
         if (cmd_read)
            step_q <= 3'd0;
         else if (cmd_load && step_q != 3'd7)
            step_q <= step_q + 3'd1;   // Saturates
      end
   end

   assign ctl_o       = ctl_q;
   assign load_step_o = step_q;
   assign read_step_o = cmd_read;
   assign restart_o   = restart_q;

endmodule

//--- logic/vsm_serializer.sv
`timescale 1ns/100ps

module vsm_serializer (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  vsm_mem_pkg::fetch_ctl_t ctl_i,
   input  vsm_mem_pkg::rom_byte_t  rd_data_i,
   input  logic                    read_step_i,
   input  logic                    restart_i,
   output logic                    byte_done_o,
   output logic                    data_o
);

   vsm_mem_pkg::rom_byte_t buf_q;   // Read-ahead byte
   vsm_mem_pkg::rom_byte_t shift_q;
   logic [2:0]             cnt_q;

   always_ff @(posedge clk) begin
      if (ctl_i.fill)
         buf_q <= rd_data_i;
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q   <= 3'd0;
         shift_q <= '0;
      end else if (restart_i) begin
         // Branch comes with its low-byte fetch, Load without
         cnt_q <= ctl_i.fetch ? 3'd0 : 3'd7;
      end else if (read_step_i) begin
         cnt_q <= cnt_q + 3'd1;   // Wraps after 7
         if (cnt_q == 3'd0)
            shift_q <= buf_q;
         else
            shift_q <= {1'b0, shift_q[7:1]};   // LSB first
      end
   end

   assign byte_done_o = read_step_i && (cnt_q == 3'd7);
   assign data_o      = shift_q[0];

endmodule

//--- logic/vsm_top.sv
`timescale 1ns/100ps

module vsm_top (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  vsm_cmd_pkg::host_cmd_t host_i,
   input  vsm_mem_pkg::bus_req_t  bus_i,
   output vsm_mem_pkg::bus_rsp_t  bus_o,
   output logic                   data_o
);

   vsm_mem_pkg::fetch_ctl_t        ctl;
   vsm_mem_pkg::rom_byte_t         rd_data;
   logic [vsm_mem_pkg::ADDR_W-1:0] ptr;
   logic [2:0]                     load_step;
   logic                           read_step;
   logic                           restart;
   logic                           byte_done;
   logic                           fetch_valid;

   vsm_sequencer u_sequencer (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .host_i        (host_i),
      .byte_done_i   (byte_done),
      .fetch_valid_i (fetch_valid),
      .ctl_o         (ctl),
      .load_step_o   (load_step),
      .read_step_o   (read_step),
      .restart_o     (restart)
   );

   vsm_addr_counter u_addr_counter (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .host_i      (host_i),
      .load_step_i (load_step),
      .ctl_i       (ctl),
      .rd_data_i   (rd_data),
      .ptr_o       (ptr)
   );

   vsm_rom_array u_rom_array (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .bus_i         (bus_i),
      .bus_o         (bus_o),
      .ctl_i         (ctl),
      .ptr_i         (ptr),
      .rd_data_o     (rd_data),
      .fetch_valid_o (fetch_valid)
   );

   vsm_serializer u_serializer (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .ctl_i       (ctl),
      .rd_data_i   (rd_data),
      .read_step_i (read_step),
      .restart_i   (restart),
      .byte_done_o (byte_done),
      .data_o      (data_o)
   );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module vsm_tb \
   -Mdir obj_dir -o vsm_sim
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

./obj_dir/vsm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
   echo "Result: pass"
   exit 0
else
   echo "Result: fail"
   exit 1
fi

//--- test/vsm_clk_gen.sv
`timescale 1ns/100ps

module vsm_clk_gen (
   output logic clk,
   output logic rst_n_o
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n_o = 1'b1;   // Released away from the active edge
   end

endmodule

//--- test/vsm_sva.sv
`timescale 1ns/100ps

module vsm_sva (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  vsm_mem_pkg::fetch_ctl_t ctl_i,
   input  logic                    fetch_valid_i,
   input  logic                    ack_i
);

   logic lo_seen_q;   // Low branch byte kept, jump may follow

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i)
         lo_seen_q <= 1'b0;
      else if (ctl_i.lo_capture)
         lo_seen_q <= 1'b1;
      else if (ctl_i.jump)
         lo_seen_q <= 1'b0;
   end

   a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      ack_i |=> !ack_i)
      else $error("ack high for two cycles in a row");

   a_fetch_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
      ctl_i.fetch |=> fetch_valid_i)
      else $error("fetch_valid missing one cycle after fetch");

   a_valid_cause: assert property (@(posedge clk) disable iff (!rst_n_i)
      fetch_valid_i |-> $past(ctl_i.fetch))
      else $error("fetch_valid without a fetch in the cycle before");

   a_jump_order: assert property (@(posedge clk) disable iff (!rst_n_i)
      ctl_i.jump |-> lo_seen_q)
      else $error("jump without a preceding lo_capture");

endmodule

bind vsm_rom_array vsm_sva u_sva (
   .clk           (clk),
   .rst_n_i       (rst_n_i),
   .ctl_i         (ctl_i),
   .fetch_valid_i (fetch_valid_o),
   .ack_i         (bus_o.ack)
);

//--- test/vsm_tb.sv
`timescale 1ns/100ps

module vsm_tb;

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_BUS_READ,
      OP_LOAD,
      OP_DUMMY,
      OP_READ_BYTE,
      OP_BRANCH
   } op_e;

   typedef struct packed {
      op_e                            op;
      logic [vsm_mem_pkg::ADDR_W-1:0] adr;
      vsm_mem_pkg::rom_byte_t         dat;    // Load count for OP_LOAD
      vsm_mem_pkg::rom_byte_t         exp;
      logic                           hold;   // Host read after the last strobe
   } entry_t;

   logic                   clk;
   logic                   rst_n;
   logic                   ser_bit;
   vsm_cmd_pkg::host_cmd_t host;
   vsm_mem_pkg::bus_req_t  bus_req;
   vsm_mem_pkg::bus_rsp_t  bus_rsp;
   entry_t                 tbl [$];
   vsm_mem_pkg::rom_byte_t model [vsm_mem_pkg::ROM_DEPTH];
   logic [31:0]            lcg_q = 32'h817e;
   logic                   table_ready = 1'b0;
   logic                   req_at_edge = 1'b0;

   vsm_clk_gen u_clk_gen (.clk(clk), .rst_n_o(rst_n));

   vsm_top u_dut (
      .clk     (clk),
      .rst_n_i (rst_n),
      .host_i  (host),
      .bus_i   (bus_req),
      .bus_o   (bus_rsp),
      .data_o  (ser_bit)
   );

   function automatic logic [31:0] lcg_next();
      lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
      return lcg_q;
   endfunction

   function automatic vsm_mem_pkg::rom_byte_t model_at(logic [17:0] adr);
      return model[adr[vsm_mem_pkg::ROM_AW-1:0]];   // Index wraps on 14 bits
   endfunction

   function automatic void add_entry(op_e op, logic [17:0] adr,
                                     vsm_mem_pkg::rom_byte_t dat,
                                     vsm_mem_pkg::rom_byte_t exp, logic hold);
      entry_t e;
      e.op   = op;
      e.adr  = adr;
      e.dat  = dat;
      e.exp  = exp;
      e.hold = hold;
      tbl.push_back(e);
   endfunction

   function automatic void add_write(logic [17:0] adr, vsm_mem_pkg::rom_byte_t dat);
      model[adr[vsm_mem_pkg::ROM_AW-1:0]] = dat;
      add_entry(OP_WRITE, adr, dat, 8'h00, 1'b0);
   endfunction

   function automatic void build_table();
      logic [31:0]            r;
      logic [17:0]            adr [6];
      logic [17:0]            a;
      logic [17:0]            t;
      vsm_mem_pkg::rom_byte_t lo;
      vsm_mem_pkg::rom_byte_t hi;
      for (int i = 0; i < 6; i++) begin
         r = lcg_next();
         adr[i] = r[25:8];
         r = lcg_next();
         add_write(adr[i], r[23:16]);
      end
      for (int i = 0; i < 6; i++)
         add_entry(OP_BUS_READ, adr[i], 8'h00, model_at(adr[i]), 1'b0);
      // Sequential read, then the same with extra loads and high pointer bits
      for (int k = 0; k < 2; k++) begin
         r = lcg_next();
         a = r[25:8];
         a[7] = 1'b0;
         if (k == 1)
            a[17] = 1'b1;   // Above ROM_DEPTH
         r = lcg_next();
         add_write(a, r[23:16]);
         add_write(a + 18'd1, r[15:8]);
         add_entry(OP_LOAD, a, 8'(vsm_cmd_pkg::LOAD_STEPS + 2 * k), 8'h00, 1'b0);
         add_entry(OP_DUMMY, a, 8'h00, 8'h00, 1'b0);
         add_entry(OP_READ_BYTE, a, 8'h00, model_at(a), 1'b0);
         add_entry(OP_READ_BYTE, a + 18'd1, 8'h00, model_at(a + 18'd1), 1'b0);
      end
      // Branch target lands in the other half of the ROM
      r = lcg_next();
      a = r[25:8];
      a[7] = 1'b0;
      r = lcg_next();
      lo = r[23:16];
      hi = {r[7:6], a[13:8] ^ 6'h20};
      t = {a[17:14], hi[5:0], lo};
      add_write(a, lo);
      add_write(a + 18'd1, hi);
      r = lcg_next();
      add_write(t, r[23:16]);
      add_write(t + 18'd1, r[15:8]);
      add_entry(OP_LOAD, a, 8'(vsm_cmd_pkg::LOAD_STEPS), 8'h00, 1'b0);
      add_entry(OP_BRANCH, a, 8'h00, 8'h00, 1'b0);
      add_entry(OP_READ_BYTE, t, 8'h00, model_at(t), 1'b0);
      add_entry(OP_READ_BYTE, adr[0], model_at(adr[0]), model_at(t + 18'd1), 1'b1);
   endfunction

   function automatic logic [3:0] load_nibble(logic [17:0] adr, int n);
      logic [31:0] r;
      if (n < 4)
         return adr[4*n +: 4];
      if (n == 4)
         return {2'b00, adr[17:16]};
      r = lcg_next();
      return r[19:16];   // Extra load, must be ignored
   endfunction

   task automatic fail_stop(string why);
      $display("%s at %0t", why, $time);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_bus(string name, vsm_mem_pkg::bus_rsp_t exp,
                            vsm_mem_pkg::bus_rsp_t act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
         fail_stop("bus response differs");
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
         fail_stop("bit value differs");
      end
   endtask

   task automatic check_ptr_byte(vsm_mem_pkg::rom_byte_t exp, vsm_mem_pkg::rom_byte_t act);
      if (act !== exp) begin
         $display("ERR %0t data_o byte exp=%h act=%h", $time, exp, act);
         fail_stop("serial byte differs");
      end
   endtask

   // All drivers start and end just after a falling edge
   task automatic send_cmd(vsm_cmd_pkg::vsm_cmd_e mode, logic [3:0] nib);
      host.mode   = mode;
      host.nibble = nib;
      host.strobe = 1'b1;
      @(negedge clk);
      host = '0;
   endtask

   task automatic bus_access(logic [17:0] adr, vsm_mem_pkg::rom_byte_t dat, logic we,
                             output vsm_mem_pkg::bus_rsp_t rsp, output int lat);
      bus_req.adr = adr;
      bus_req.dat = dat;
      bus_req.we  = we;
      bus_req.sel = 1'b1;
      bus_req.stb = 1'b1;
      bus_req.cyc = 1'b1;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
         if (lat > 8)
            fail_stop("no acknowledge on the bus");
      end while (!bus_rsp.ack);
      rsp = bus_rsp;
      bus_req = '0;
      @(negedge clk);   // Idle cycle between accesses
   endtask

   task automatic read_byte(vsm_mem_pkg::rom_byte_t exp, logic hold,
                            logic [17:0] hadr, vsm_mem_pkg::rom_byte_t hdat);
      vsm_mem_pkg::rom_byte_t got;
      vsm_mem_pkg::bus_rsp_t  rsp;
      vsm_mem_pkg::bus_rsp_t  want;
      int                     lat;
      for (int i = 0; i < 8; i++) begin
         send_cmd(vsm_cmd_pkg::CMD_READ, 4'h0);
         got[i] = ser_bit;
         if (hold && i == 7) begin
            bus_access(hadr, 8'h00, 1'b0, rsp, lat);
            want.dat = hdat;
            want.ack = 1'b1;
            check_bus("bus_o", want, rsp);
            if (lat != 2)
               fail_stop("host read was not held off by the fetch");
         end
         repeat (7) @(negedge clk);
      end
      check_ptr_byte(exp, got);
   endtask

   task automatic run_entry(entry_t e);
      vsm_mem_pkg::bus_rsp_t rsp;
      vsm_mem_pkg::bus_rsp_t want;
      int                    lat;
      case (e.op)
         OP_WRITE: begin
            bus_access(e.adr, e.dat, 1'b1, rsp, lat);
            if (lat != 1)
               fail_stop("bus write acknowledged late");
         end
         OP_BUS_READ: begin
            bus_access(e.adr, 8'h00, 1'b0, rsp, lat);
            want.dat = e.exp;
            want.ack = 1'b1;
            check_bus("bus_o", want, rsp);
            if (lat != 1)
               fail_stop("bus read acknowledged late with no fetch pending");
         end
         OP_LOAD: begin
            for (int n = 0; n < int'(e.dat); n++)
               send_cmd(vsm_cmd_pkg::CMD_LOAD, load_nibble(e.adr, n));
            @(negedge clk);
         end
         OP_DUMMY: begin
            send_cmd(vsm_cmd_pkg::CMD_READ, 4'h0);
            repeat (7) @(negedge clk);
         end
         OP_BRANCH: begin
            send_cmd(vsm_cmd_pkg::CMD_BRANCH, 4'h0);
            repeat (11) @(negedge clk);   // Two fetches, jump and target fetch
         end
         default: read_byte(e.exp, e.hold, e.adr, e.dat);
      endcase
   endtask

   always @(posedge clk)
      req_at_edge <= bus_req.cyc && bus_req.stb;

   always @(negedge clk) begin
      if (rst_n && bus_rsp.ack && !req_at_edge)
         fail_stop("acknowledge seen without an active bus request");
   end

   initial begin
      int limit_ns;
      wait (table_ready);
      limit_ns = tbl.size() * 40 * 4;
      #(limit_ns);
      fail_stop("watchdog timeout, the run did not finish in time");
   end

   initial begin
      host    = '0;
      bus_req = '0;
      build_table();
      table_ready = 1'b1;
      @(posedge rst_n);
      @(negedge clk);
      check_bit("data_o", 1'b0, ser_bit);
      check_bit("bus_o.ack", 1'b0, bus_rsp.ack);
      foreach (tbl[i])
         run_entry(tbl[i]);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
